//--- cpuPkg.sv
package cpuPkg;

    parameter int wordSize = 16;
    parameter int numRegs = 4;
    parameter int regAddrW = 2;

    // instruction opcodes, bits 15:12.
    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opJal   = 4'd10,
        opRsv11 = 4'd11,
        opRsv12 = 4'd12,
        opRsv13 = 4'd13,
        opRsv14 = 4'd14,
        opRType = 4'd15
    } opcodeT;

    // function codes for opcode 15.
    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnNot = 6'd4,
        fnTcp = 6'd5,
        fnShl = 6'd6,
        fnShr = 6'd7,
        fnJpr = 6'd25,
        fnJrl = 6'd26,
        fnHlt = 6'd29
    } funcT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluNot   = 4'd4,
        aluTcp   = 4'd5,
        aluShl   = 4'd6,
        aluShr   = 4'd7,
        aluPassB = 4'd8 // lhi.
    } aluOpT;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int dataWidth = cpuPkg::wordSize
) (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  cpuPkg::aluOpT        op,
    output logic [dataWidth-1:0] result
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluNot: begin
                result = ~a;
            end
            aluTcp: begin
                result = ~a + 1'b1; // negate.
            end
            aluShl: begin
                result = {a[dataWidth-2:0], 1'b0};
            end
            aluShr: begin
                result = {a[dataWidth-1], a[dataWidth-1:1]}; // arithmetic.
            end
            aluPassB: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // decoder must never hand over an undefined operation.
    always_comb begin
        assert final (op inside {aluAdd, aluSub, aluAnd, aluOr, aluNot,
                                 aluTcp, aluShl, aluShr, aluPassB})
        else $error("alu: undefined op %0d", op);
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter int dataWidth = cpuPkg::wordSize
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [cpuPkg::regAddrW-1:0] readAddr1,
    input  logic [cpuPkg::regAddrW-1:0] readAddr2,
    input  logic [cpuPkg::regAddrW-1:0] writeAddr,
    input  logic [dataWidth-1:0]        writeData,
    input  logic                        writeEnable,
    output logic [dataWidth-1:0]        readData1,
    output logic [dataWidth-1:0]        readData2
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // combinational reads, new value visible after the edge.
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

//--- controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  cpuPkg::opcodeT opcode,
    input  logic [5:0]     func,
    output logic           regWrite,
    output logic           regDst,
    output logic           aluSrc,
    output cpuPkg::aluOpT  aluOp,
    output logic           memToReg,
    output logic           isBranch,
    output logic           isJump,
    output logic           isLink,
    output logic           isJumpReg,
    output logic           memRead,
    output logic           memWrite,
    output logic           halt
);
    import cpuPkg::*;

    always_comb begin
        regWrite  = 1'b0;
        regDst    = 1'b0;
        aluSrc    = 1'b0;
        aluOp     = aluAdd;
        memToReg  = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;
        isLink    = 1'b0;
        isJumpReg = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        halt      = 1'b0;

        case (opcode)
            opBne, opBeq, opBgz, opBlz: begin
                isBranch = 1'b1; // condition tested in the datapath.
            end
            opAdi, opOri, opLhi: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = (opcode == opAdi) ? aluAdd :
                           (opcode == opOri) ? aluOr : aluPassB;
            end
            opLwd: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                memRead  = 1'b1;
            end
            opSwd: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            opJmp, opJal: begin
                isJump   = 1'b1;
                isLink   = (opcode == opJal);
                regWrite = (opcode == opJal);
            end
            opRType: begin
                case (funcT'(func))
                    fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
                        regWrite = 1'b1;
                        regDst   = 1'b1;
                        aluOp    = aluOpT'({1'b0, func[2:0]}); // codes line up.
                    end
                    fnJpr: isJumpReg = 1'b1;
                    fnJrl: begin
                        isJumpReg = 1'b1;
                        isLink    = 1'b1;
                        regWrite  = 1'b1;
                    end
                    fnHlt: halt = 1'b1;
                    default: ; // reserved function, no operation.
                endcase
            end
            default: ; // reserved opcode, no operation.
        endcase
    end

endmodule

//--- datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter int dataWidth = cpuPkg::wordSize
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 regWrite,
    input  logic                 regDst,
    input  logic                 aluSrc,
    input  cpuPkg::aluOpT        aluOp,
    input  logic                 memToReg,
    input  logic                 isBranch,
    input  logic                 isJump,
    input  logic                 isLink,
    input  logic                 isJumpReg,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic                 halt,
    input  logic [dataWidth-1:0] dataIn,
    input  logic                 inputReady,
    input  logic                 ackOutput,
    output cpuPkg::opcodeT       opcode,
    output logic [5:0]           func,
    output logic                 readM,
    output logic                 writeM,
    output logic [dataWidth-1:0] address,
    output logic [dataWidth-1:0] dataOut,
    output logic                 halted
);
    import cpuPkg::*;

    typedef enum logic [2:0] {
        sStart,
        sFetch,
        sExecute,
        sMemRead,
        sMemWrite,
        sHalt
    } stateT;

    stateT state;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] ir;
    logic [dataWidth-1:0] memAddr;
    logic [dataWidth-1:0] storeData;

    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] writeAddr;
    logic [7:0]          imm;
    logic [11:0]         target;

    logic [dataWidth-1:0] immSext;
    logic [dataWidth-1:0] immHigh;
    logic [dataWidth-1:0] pcPlus1;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] nextPc;
    logic [dataWidth-1:0] readData1;
    logic [dataWidth-1:0] readData2;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] writeData;
    logic                 writeEnable;
    logic                 taken;

    // fields sit in the low half word.
    assign opcode = opcodeT'(ir[15:12]);
    assign rs     = ir[11:10];
    assign rt     = ir[9:8];
    assign rd     = ir[7:6];
    assign func   = ir[5:0];
    assign imm    = ir[7:0];
    assign target = ir[11:0];

    assign immSext = {{(dataWidth-8){imm[7]}}, imm};
    assign immHigh = {imm, {(dataWidth-8){1'b0}}}; // lhi operand.
    assign aluB    = !aluSrc ? readData2 : (aluOp == aluPassB) ? immHigh : immSext;

    assign pcPlus1      = pc + 1'b1;
    assign branchTarget = pcPlus1 + immSext;

    always_comb begin
        case (opcode)
            opBne:   taken = (readData1 != readData2);
            opBeq:   taken = (readData1 == readData2);
            opBgz:   taken = ($signed(readData1) > 0);
            opBlz:   taken = ($signed(readData1) < 0);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (isJump) begin
            nextPc = {pc[dataWidth-1:12], target};
        end else if (isJumpReg) begin
            nextPc = readData1;
        end else if (isBranch && taken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus1;
        end
    end

    // links always go to register 2.
    assign writeAddr = isLink ? 2'd2 : (regDst ? rd : rt);
    assign writeData = (state == sMemRead) ? dataIn : (isLink ? pcPlus1 : aluResult);
    assign writeEnable = (state == sExecute && regWrite && !memToReg) ||
                         (state == sMemRead && inputReady);

    regFile #(.dataWidth(dataWidth)) regFile_inst (
        .clk        (clk),
        .rstN       (rstN),
        .readAddr1  (rs),
        .readAddr2  (rt),
        .writeAddr  (writeAddr),
        .writeData  (writeData),
        .writeEnable(writeEnable),
        .readData1  (readData1),
        .readData2  (readData2)
    );

    alu #(.dataWidth(dataWidth)) alu_inst (
        .a     (readData1),
        .b     (aluB),
        .op    (aluOp),
        .result(aluResult)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sStart;
            pc    <= '0;
            ir    <= '0;
        end else begin
            case (state)
                sStart: state <= sFetch;
                sFetch: begin
                    if (inputReady) begin
                        ir    <= dataIn;
                        state <= sExecute;
                    end
                end
                sExecute: begin
                    pc <= nextPc;
                    if (halt) begin
                        state <= sHalt;
                    end else if (memRead) begin
                        state <= sMemRead;
                    end else if (memWrite) begin
                        state <= sMemWrite;
                    end else begin
                        state <= sFetch;
                    end
                end
                sMemRead: begin
                    if (inputReady) state <= sFetch;
                end
                sMemWrite: begin
                    if (ackOutput) state <= sFetch;
                end
                default: state <= sHalt; // stays until reset.
            endcase
        end
    end

    // address and store data held for the whole access.
    always_ff @(posedge clk) begin
        if (state == sExecute) begin
            memAddr   <= aluResult;
            storeData <= readData2;
        end
    end

    assign readM   = (state == sFetch) || (state == sMemRead);
    assign writeM  = (state == sMemWrite);
    assign halted  = (state == sHalt);
    assign address = (state == sFetch) ? pc : memAddr;
    assign dataOut = storeData;

    assert property (@(posedge clk) disable iff (!rstN) !(readM && writeM))
    else $error("datapath: readM and writeM high together");

    assert property (@(posedge clk) disable iff (!rstN)
        writeM && !ackOutput |=> writeM && $stable(address))
    else $error("datapath: writeM dropped or address moved before ackOutput");

endmodule

//--- cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
    parameter int dataWidth = cpuPkg::wordSize
) (
    input  logic                 clk,
    input  logic                 rstN,
    output logic                 readM,
    output logic                 writeM,
    output logic [dataWidth-1:0] address,
    output logic [dataWidth-1:0] dataOut,
    input  logic [dataWidth-1:0] dataIn,
    input  logic                 inputReady,
    input  logic                 ackOutput,
    output logic                 halted
);
    import cpuPkg::*;

    opcodeT     opcode;
    logic [5:0] func;
    aluOpT      aluOp;
    logic       regWrite;
    logic       regDst;
    logic       aluSrc;
    logic       memToReg;
    logic       isBranch;
    logic       isJump;
    logic       isLink;
    logic       isJumpReg;
    logic       memRead;
    logic       memWrite;
    logic       halt;

    controlUnit controlUnit_inst (
        .opcode   (opcode),
        .func     (func),
        .regWrite (regWrite),
        .regDst   (regDst),
        .aluSrc   (aluSrc),
        .aluOp    (aluOp),
        .memToReg (memToReg),
        .isBranch (isBranch),
        .isJump   (isJump),
        .isLink   (isLink),
        .isJumpReg(isJumpReg),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halt     (halt)
    );

    datapath #(.dataWidth(dataWidth)) datapath_inst (
        .clk       (clk),
        .rstN      (rstN),
        .regWrite  (regWrite),
        .regDst    (regDst),
        .aluSrc    (aluSrc),
        .aluOp     (aluOp),
        .memToReg  (memToReg),
        .isBranch  (isBranch),
        .isJump    (isJump),
        .isLink    (isLink),
        .isJumpReg (isJumpReg),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .halt      (halt),
        .dataIn    (dataIn),
        .inputReady(inputReady),
        .ackOutput (ackOutput),
        .opcode    (opcode),
        .func      (func),
        .readM     (readM),
        .writeM    (writeM),
        .address   (address),
        .dataOut   (dataOut),
        .halted    (halted)
    );

endmodule

//--- tbMemory.sv
`timescale 1ns/1ps

module tbMemory #(
    parameter int dataWidth = cpuPkg::wordSize
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 readM,
    input  logic                 writeM,
    input  logic [dataWidth-1:0] address,
    input  logic [dataWidth-1:0] dataOut,
    output logic [dataWidth-1:0] dataIn,
    output logic                 inputReady,
    output logic                 ackOutput
);
    import cpuPkg::*;

    localparam int memWords = 256;

    logic [dataWidth-1:0] mem [memWords];
    logic [15:0]          rndState;
    logic                 busy;
    logic [1:0]           waitLeft; // idle cycles still to go.

    function automatic logic [15:0] nextRandom(input logic [15:0] x);
        logic [15:0] y;
        y = x ^ (x << 7);
        y = y ^ (y >> 9);
        y = y ^ (y << 8);
        return y;
    endfunction

    function automatic logic [15:0] encodeI(input opcodeT op, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] encodeR(input logic [1:0] rs, input logic [1:0] rt,
                                            input logic [1:0] rd, input funcT fn);
        return {opRType, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encodeJ(input opcodeT op, input logic [11:0] target);
        return {op, target};
    endfunction

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = dataWidth'({8'hE0, 8'(i)}); // reserved opcode, runs as a no-op.
        end
        mem[0]  = encodeI(opAdi, 2'd0, 2'd3, 8'h70); // r3 is the store base.
        mem[1]  = encodeI(opAdi, 2'd0, 2'd0, 8'h05);
        mem[2]  = encodeI(opAdi, 2'd1, 2'd1, 8'hFD);
        mem[3]  = encodeR(2'd0, 2'd1, 2'd2, fnAdd);
        mem[4]  = encodeI(opSwd, 2'd3, 2'd2, 8'h10);
        mem[5]  = encodeR(2'd0, 2'd1, 2'd2, fnSub);
        mem[6]  = encodeI(opSwd, 2'd3, 2'd2, 8'h11);
        mem[7]  = encodeR(2'd0, 2'd1, 2'd2, fnAnd);
        mem[8]  = encodeI(opSwd, 2'd3, 2'd2, 8'h12);
        mem[9]  = encodeR(2'd0, 2'd1, 2'd2, fnOrr);
        mem[10] = encodeI(opSwd, 2'd3, 2'd2, 8'h13);
        mem[11] = encodeR(2'd0, 2'd0, 2'd2, fnNot);
        mem[12] = encodeI(opSwd, 2'd3, 2'd2, 8'h14);
        mem[13] = encodeR(2'd1, 2'd0, 2'd2, fnTcp);
        mem[14] = encodeI(opSwd, 2'd3, 2'd2, 8'h15);
        mem[15] = encodeR(2'd1, 2'd0, 2'd2, fnShl);
        mem[16] = encodeI(opSwd, 2'd3, 2'd2, 8'h16);
        mem[17] = encodeR(2'd0, 2'd0, 2'd2, fnShr);
        mem[18] = encodeI(opSwd, 2'd3, 2'd2, 8'h17);
        mem[19] = encodeI(opOri, 2'd0, 2'd2, 8'h30);
        mem[20] = encodeI(opSwd, 2'd3, 2'd2, 8'h18);
        mem[21] = encodeI(opLhi, 2'd0, 2'd2, 8'hA5);
        mem[22] = encodeI(opSwd, 2'd3, 2'd2, 8'h19);
        mem[23] = encodeI(opSwd, 2'd3, 2'd1, 8'h1A);
        mem[24] = encodeI(opLwd, 2'd3, 2'd2, 8'hF0); // reads word 0x60.
        mem[25] = encodeI(opSwd, 2'd3, 2'd2, 8'h1B);
        mem[26] = encodeI(opBne, 2'd0, 2'd1, 8'h01); // taken.
        mem[28] = encodeI(opBne, 2'd0, 2'd0, 8'h01);
        mem[29] = encodeI(opBeq, 2'd0, 2'd0, 8'h01); // taken.
        mem[31] = encodeI(opBeq, 2'd0, 2'd1, 8'h01);
        mem[32] = encodeI(opBgz, 2'd0, 2'd0, 8'h01); // taken.
        mem[34] = encodeI(opBgz, 2'd1, 2'd0, 8'h01);
        mem[35] = encodeI(opBlz, 2'd1, 2'd0, 8'h01); // taken.
        mem[37] = encodeI(opBlz, 2'd0, 2'd0, 8'h01);
        mem[38] = encodeJ(opJmp, 12'd40);
        mem[40] = encodeJ(opJal, 12'd43);
        mem[43] = encodeI(opSwd, 2'd3, 2'd2, 8'h1C);
        mem[44] = encodeI(opAdi, 2'd3, 2'd1, 8'hC0); // r1 = 48.
        mem[45] = encodeR(2'd1, 2'd0, 2'd0, fnJpr);
        mem[48] = encodeI(opAdi, 2'd1, 2'd1, 8'h04);
        mem[49] = encodeR(2'd1, 2'd0, 2'd0, fnJrl);
        mem[52] = encodeI(opSwd, 2'd3, 2'd2, 8'h1D);
        // skipped slots halt early, so a wrong path shows up.
        foreach (mem[i]) begin
            if (i inside {27, 30, 33, 36, 39, 41, 42, 46, 47, 50, 51, 53}) begin
                mem[i] = encodeR(2'd0, 2'd0, 2'd0, fnHlt);
            end
        end
        mem[96] = 16'h5A3C;
    end

    always @(posedge clk or negedge rstN) begin
        logic fire;
        fire = 1'b0;
        if (!rstN) begin
            dataIn     <= '0;
            inputReady <= 1'b0;
            ackOutput  <= 1'b0;
            busy       <= 1'b0;
            waitLeft   <= 2'd0;
            rndState   <= 16'd75;
        end else begin
            inputReady <= 1'b0;
            ackOutput  <= 1'b0;
            if (inputReady || ackOutput) begin
                busy <= 1'b0; // strobe still shows the access just answered.
            end else if (readM || writeM) begin
                if (!busy) begin
                    rndState <= nextRandom(rndState);
                    if (rndState[1:0] == 2'd0) begin
                        fire = 1'b1;
                    end else begin
                        busy     <= 1'b1;
                        waitLeft <= rndState[1:0] - 2'd1;
                    end
                end else if (waitLeft != 2'd0) begin
                    waitLeft <= waitLeft - 2'd1;
                end else begin
                    fire = 1'b1;
                end
            end
            if (fire && readM) begin
                dataIn     <= mem[address[7:0]];
                inputReady <= 1'b1;
            end else if (fire) begin
                mem[address[7:0]] = dataOut;
                ackOutput <= 1'b1;
            end
        end
    end

endmodule

//--- tbCpu.sv
`timescale 1ns/1ps

module tbCpu;
    import cpuPkg::*;

    localparam int dataWidth = wordSize;
    localparam int clkPeriod = 100;
    localparam int numStores = 14;
    localparam int numReads = 44;
    localparam int worstCycles = 11; // five-cycle fetch, execute, five-cycle data access.
    localparam int timeoutCycles = numReads * worstCycles + 50;

    // reads that follow the straight-line fetches 0 to 24.
    localparam int lateReads [19] = '{'h60, 25, 26, 28, 29, 31, 32, 34, 35, 37,
                                      38, 40, 43, 44, 45, 48, 49, 52, 53};

    // r0 = 5, r1 = -3 for the alu part.
    localparam logic [dataWidth-1:0] storeAddr [numStores] = '{
        'h80, 'h81, 'h82, 'h83, 'h84, 'h85, 'h86,
        'h87, 'h88, 'h89, 'h8A, 'h8B, 'h8C, 'h8D
    };
    localparam logic [dataWidth-1:0] storeData [numStores] = '{
        'h0002, // add.
        'h0008, // sub.
        'h0005, // and.
        'hFFFD, // orr.
        'hFFFA, // not of 5.
        'h0003, // tcp of -3.
        'hFFFA, // shl of -3.
        'h0002, // shr of 5.
        'h0035, // ori 0x30.
        'hA500, // lhi.
        'hFFFD, // adi result in r1.
        'h5A3C, // loaded word.
        'h0029, // jal at 40.
        'h0032  // jrl at 49.
    };

    logic                 clk;
    logic                 rstN;
    logic                 readM;
    logic                 writeM;
    logic                 halted;
    logic                 inputReady;
    logic                 ackOutput;
    logic [dataWidth-1:0] address;
    logic [dataWidth-1:0] dataOut;
    logic [dataWidth-1:0] dataIn;
    logic [dataWidth-1:0] expReads [numReads];

    int readCount;
    int storeCount;
    int valueErrors = 0;
    int protocolErrors = 0;

    cpuTop #(.dataWidth(dataWidth)) cpuTop_inst (
        .clk       (clk),
        .rstN      (rstN),
        .readM     (readM),
        .writeM    (writeM),
        .address   (address),
        .dataOut   (dataOut),
        .dataIn    (dataIn),
        .inputReady(inputReady),
        .ackOutput (ackOutput),
        .halted    (halted)
    );

    tbMemory #(.dataWidth(dataWidth)) tbMemory_inst (
        .clk       (clk),
        .rstN      (rstN),
        .readM     (readM),
        .writeM    (writeM),
        .address   (address),
        .dataOut   (dataOut),
        .dataIn    (dataIn),
        .inputReady(inputReady),
        .ackOutput (ackOutput)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readCount  <= 0;
            storeCount <= 0;
        end else begin
            if (readM && inputReady) readCount <= readCount + 1;
            if (writeM && ackOutput) storeCount <= storeCount + 1;
        end
    end

    quietInReset: assert property (@(posedge clk)
        (!rstN || $rose(rstN)) |-> !readM && !writeM && !halted)
    else begin
        protocolErrors++;
        $display("strobe or halted high during reset or the start cycle at %0t", $time);
    end

    noDoubleStrobe: assert property (@(posedge clk) disable iff (!rstN) !(readM && writeM))
    else begin
        protocolErrors++;
        $display("readM and writeM high together at %0t", $time);
    end

    readHeld: assert property (@(posedge clk) disable iff (!rstN)
        readM && !inputReady |=> readM && $stable(address))
    else begin
        protocolErrors++;
        $display("readM dropped or its address moved before inputReady at %0t", $time);
    end

    writeHeld: assert property (@(posedge clk) disable iff (!rstN)
        writeM && !ackOutput |=> writeM && $stable(address) && $stable(dataOut))
    else begin
        protocolErrors++;
        $display("writeM dropped or its address or data moved before ackOutput at %0t", $time);
    end

    readInTable: assert property (@(posedge clk) disable iff (!rstN)
        readM && inputReady |-> readCount < numReads)
    else begin
        protocolErrors++;
        $display("more reads than the program path allows at %0t", $time);
    end

    readAddrOk: assert property (@(posedge clk) disable iff (!rstN)
        readM && inputReady |-> address == expReads[readCount])
    else begin
        valueErrors++;
        $display("[FAIL] %0t address (read): expected %h, got %h", $time,
                 expReads[$sampled(readCount)], $sampled(address));
    end

    storeInTable: assert property (@(posedge clk) disable iff (!rstN)
        writeM && ackOutput |-> storeCount < numStores)
    else begin
        protocolErrors++;
        $display("more stores than expected at %0t", $time);
    end

    storeAddrOk: assert property (@(posedge clk) disable iff (!rstN)
        writeM && ackOutput |-> address == storeAddr[storeCount])
    else begin
        valueErrors++;
        $display("[FAIL] %0t address (store): expected %h, got %h", $time,
                 storeAddr[$sampled(storeCount)], $sampled(address));
    end

    storeDataOk: assert property (@(posedge clk) disable iff (!rstN)
        writeM && ackOutput |-> dataOut == storeData[storeCount])
    else begin
        valueErrors++;
        $display("[FAIL] %0t dataOut: expected %h, got %h", $time,
                 storeData[$sampled(storeCount)], $sampled(dataOut));
    end

    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted && !readM && !writeM)
    else begin
        protocolErrors++;
        $display("halted dropped or a strobe followed the halt at %0t", $time);
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        $display("watchdog: CPU did not halt within %0d cycles", timeoutCycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        for (int i = 0; i < 25; i++) begin
            expReads[i] = dataWidth'(i);
        end
        for (int i = 0; i < 19; i++) begin
            expReads[25 + i] = dataWidth'(lateReads[i]);
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        while (!halted) @(posedge clk);
        repeat (8) @(posedge clk); // quiet bus after the halt.
        assert (storeCount == numStores)
        else begin
            protocolErrors++;
            $display("saw %0d stores, expected %0d", storeCount, numStores);
        end
        assert (readCount == numReads)
        else begin
            protocolErrors++;
            $display("saw %0d reads, expected %0d", readCount, numReads);
        end
        $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
cpuPkg.sv
alu.sv
regFile.sv
controlUnit.sv
datapath.sv
cpuTop.sv
tbMemory.sv
tbCpu.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the CPU testbench with Verilator, then checks the log.

cd "$(dirname "$0")" || exit 1

logFile="sim.log"
buildDir="obj_dir"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbCpu -Mdir "$buildDir" -o tbCpuSim -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/tbCpuSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TB PASSED" "$logFile"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
